/* list.f */
uart_pkg.sv
fifo_push_if.sv
uart_wb_regs.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_uart_tx.sv

/* Makefile */
# Verilator build and run for the UART transmitter testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_uart_tx \
		-f list.f -Mdir obj_dir
	./obj_dir/Vtb_uart_tx > sim.log 2>&1 || true
	cat sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_uart_tx.sv */
// Testbench for the UART transmitter with clock, bus tasks, txd sampler, reference and test sequence
`timescale 1ns/1ps

module tb_uart_tx
   import uart_pkg::*;
();

   localparam int          FIFO_DEPTH   = 8;       // Bytes the DUT queues
   localparam int          ACK_TIMEOUT  = 2000;    // Cycles to cover a full FIFO stall
   localparam int          EDGE_TIMEOUT = 4000;    // Cycles to wait for a start bit
   localparam int          IDLE_POLLS   = 200;     // Status reads before giving up
   localparam logic [31:0] STATUS_IDLE  = 32'(1) << STAT_EMPTY_BIT;

   // Queue full with one byte already in the serializer
   localparam logic [31:0] STATUS_FULL  = (32'(FIFO_DEPTH) << STAT_LEVEL_LSB)
                                          | (32'(1) << STAT_FULL_BIT)
                                          | (32'(1) << STAT_BUSY_BIT);

   logic              clk, reset, cyc, stb, we, ack, txd;
   logic [ADDR_W-1:0] adr;
   logic [31:0]       dat_w, dat_r, rd;
   logic [7:0]        frames [$];                  // Bytes still to appear on txd
   logic [7:0]        batch [10];
   int                seed, rnd, cur_div;          // cur_div is the bit period in use

   uart_tx_top #(.CLK_HZ(1000000), .BAUD(125000), .FIFO_DEPTH(FIFO_DEPTH)) u_uart_tx_top (
      .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_w(dat_w), .ack(ack), .dat_r(dat_r), .txd(txd)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                       // 100 MHz in sim time
   end

   //============================================================
   // Checks and reference
   //============================================================
   task automatic compare_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("sim failed");
      $fatal(1);
   endtask

   // Line level for bit idx of a frame with start, 8 data LSB first, stop and guard
   function automatic logic frame_level(input logic [7:0] data, input int idx);
      logic level;
      if (idx == 0)
         level = 1'b0;                             // Start
      else if (idx <= 8)
         level = data[idx - 1];                    // Data LSB first
      else
         level = 1'b1;                             // Stop and guard
      return level;
   endfunction

   //============================================================
   // Wishbone master tasks
   //============================================================
   task automatic bus_cycle(input logic wr, input logic [ADDR_W-1:0] a,
                            input logic [31:0] d, output logic [31:0] q);
      int n;
      n = 0;
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = a;
      dat_w = d;
      @(negedge clk);
      if (!(wr && a == REG_DATA))                  // Only byte writes may be held off
         compare_value("ack one cycle after stb", 32'(ack), 32'd1);
      while (!ack) begin                           // Held until the slave answers
         if (n == ACK_TIMEOUT) report_timeout("ack on the Wishbone bus");
         n++;
         @(negedge clk);
      end
      q   = dat_r;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [31:0] d);
      logic [31:0] unused_q;
      bus_cycle(1'b1, a, d, unused_q);
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [31:0] q);
      bus_cycle(1'b0, a, 32'd0, q);
   endtask

   // Poll status until the serializer has finished its last guard bit
   task automatic wait_idle();
      logic [31:0] st;
      int n;
      n = 0;
      bus_read(REG_STATUS, st);
      while (st[STAT_BUSY_BIT]) begin
         if (n == IDLE_POLLS) report_timeout("the serializer to go idle");
         n++;
         bus_read(REG_STATUS, st);
      end
   endtask

   //============================================================
   // Serial line sampler
   //============================================================
   // Returns the number of falling clock edges until the start bit shows
   task automatic wait_start_edge(output int waited);
      logic prev;
      int n;
      prev = txd;
      n = 1;
      @(negedge clk);
      while (!(prev && !txd)) begin                // High then low marks the start bit
         if (n == EDGE_TIMEOUT) report_timeout("a start edge on txd");
         prev = txd;
         n++;
         @(negedge clk);
      end
      waited = n;
   endtask

   // Checks each bit at its middle and, after the start bit, half a cycle into it
   task automatic check_frames(input int count);
      logic [7:0] b;
      int         gap;
      for (int f = 0; f < count; f++) begin
         b = frames.pop_front();
         wait_start_edge(gap);
         if (f > 0)                                // Queued bytes follow the guard bit directly
            compare_value($sformatf("byte %h start after guard", b), 32'(gap),
                          32'(cur_div - cur_div / 2));
         for (int k = 0; k < FRAME_BITS; k++) begin
            if (k > 0) begin
               repeat (cur_div - cur_div / 2) @(negedge clk);
               compare_value($sformatf("byte %h bit %0d begin", b, k), 32'(txd),
                             32'(frame_level(b, k)));
            end
            repeat (cur_div / 2) @(negedge clk);
            compare_value($sformatf("byte %h bit %0d middle", b, k), 32'(txd),
                          32'(frame_level(b, k)));
         end                                       // Ends in the middle of the guard bit
      end
   endtask

   //============================================================
   // Test sequence
   //============================================================
   initial begin
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      dat_w   = '0;
      reset   = 1'b1;
      seed    = 59564;
      cur_div = 8;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      compare_value("txd after reset", 32'(txd), 32'd1);
      bus_read(REG_STATUS, rd);
      compare_value("status after reset", rd, STATUS_IDLE);
      bus_read(REG_DIVISOR, rd);
      compare_value("divisor after reset", rd, 32'd8);

      // Single frame at the reset bit period
      rnd = $random(seed);
      frames.push_back(rnd[7:0]);
      fork
         bus_write(REG_DATA, 32'(rnd[7:0]));
         check_frames(1);
      join
      wait_idle();
      bus_read(REG_STATUS, rd);
      compare_value("status after one frame", rd, STATUS_IDLE);

      // Divisor floor and then a slower frame
      bus_write(REG_DIVISOR, 32'd2);
      bus_read(REG_DIVISOR, rd);
      compare_value("divisor raised to minimum", rd, 32'(MIN_DIVISOR));
      bus_write(REG_DIVISOR, 32'd12);
      bus_read(REG_DIVISOR, rd);
      compare_value("divisor readback", rd, 32'd12);
      cur_div = 12;
      rnd = $random(seed);
      frames.push_back(rnd[7:0]);
      fork
         bus_write(REG_DATA, 32'(rnd[7:0]));
         check_frames(1);
      join

      // Burst deeper than the FIFO so later writes stall on ack
      for (int i = 0; i < 10; i++) begin
         rnd      = $random(seed);
         batch[i] = rnd[7:0];
         frames.push_back(rnd[7:0]);
      end
      fork
         for (int w = 0; w < 10; w++) begin
            bus_write(REG_DATA, 32'(batch[w]));
            if (w == 8) begin
               bus_read(REG_STATUS, rd);
               compare_value("status after ninth write", rd, STATUS_FULL);
            end
         end
         check_frames(10);
      join
      wait_idle();
      bus_read(REG_STATUS, rd);
      compare_value("status after burst", rd, STATUS_IDLE);

      bus_read(REG_DATA, rd);
      compare_value("data register read", rd, 32'd0);

      // Unused address 3
      bus_write(2'd3, 32'h0000_00A5);
      bus_read(2'd3, rd);
      compare_value("unused address read", rd, 32'd0);
      bus_read(REG_STATUS, rd);
      compare_value("status after unused access", rd, STATUS_IDLE);
      bus_read(REG_DIVISOR, rd);
      compare_value("divisor after unused access", rd, 32'd12);

      $display("sim passed");
      $finish;
   end

endmodule

/* uart_tx_top.sv */
// UART transmitter top level with Wishbone classic ports and the serial output
`timescale 1ns/1ps

module uart_tx_top
   import uart_pkg::*;
#(
   parameter int CLK_HZ     = 50_000_000,          // Core clock
   parameter int BAUD       = 115_200,             // Bit rate after reset
   parameter int FIFO_DEPTH = 8                    // Bytes queued, power of two
) (
   input  logic              clk,
   input  logic              reset,

   // Wishbone classic slave
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [ADDR_W-1:0] adr,
   input  logic [31:0]       dat_w,
   output logic              ack,
   output logic [31:0]       dat_r,

   output logic              txd                   // Serial line
);

   //============================================================
   // Internal connections
   //============================================================
   fifo_push_if #(.DEPTH(FIFO_DEPTH)) push_bus (); // Register block to FIFO

   logic [7:0]       fifo_rd_data;                 // FIFO head
   logic             fifo_empty;
   logic             ser_pop;
   logic             ser_busy;
   logic [DIV_W-1:0] divisor;

   uart_wb_regs #(
      .CLK_HZ (CLK_HZ),
      .BAUD   (BAUD)
   ) u_regs (
      .clk     (clk),
      .reset   (reset),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .dat_w   (dat_w),
      .ack     (ack),
      .dat_r   (dat_r),
      .push    (push_bus.writer),
      .busy    (ser_busy),
      .divisor (divisor)
   );

   uart_tx_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk     (clk),
      .reset   (reset),
      .push    (push_bus.buffer),
      .pop     (ser_pop),
      .rd_data (fifo_rd_data),
      .empty   (fifo_empty)
   );

   uart_tx_serializer u_ser (
      .clk     (clk),
      .reset   (reset),
      .rd_data (fifo_rd_data),
      .empty   (fifo_empty),
      .pop     (ser_pop),
      .divisor (divisor),
      .txd     (txd),
      .busy    (ser_busy)
   );

endmodule

/* uart_tx_serializer.sv */
// Baud counter and frame FSM that shifts FIFO bytes out on the serial line
`timescale 1ns/1ps

module uart_tx_serializer
   import uart_pkg::*;
(
   input  logic             clk,
   input  logic             reset,

   // FIFO read side
   input  logic [7:0]       rd_data,
   input  logic             empty,
   output logic             pop,                   // One cycle strobe

   input  logic [DIV_W-1:0] divisor,               // Bit period in clocks
   output logic             txd,                   // Serial line, idles high
   output logic             busy                   // Frame in progress
);

   //============================================================
   // Frame states
   //============================================================
   // Bit states are numbered in line order, guard is the last bit
   typedef enum logic [3:0] {
      S_START = 4'd0,
      S_D0    = 4'd1,
      S_D1    = 4'd2,
      S_D2    = 4'd3,
      S_D3    = 4'd4,
      S_D4    = 4'd5,
      S_D5    = 4'd6,
      S_D6    = 4'd7,
      S_D7    = 4'd8,
      S_STOP  = 4'd9,
      S_GUARD = 4'(FRAME_BITS - 1),                // Spacing between characters
      S_IDLE  = 4'hF
   } state_t;

   state_t           state;
   logic [DIV_W-1:0] count;                        // Clocks left in this bit
   logic [7:0]       data_q;                       // Byte being sent
   logic             bit_end;                      // Last clock of the bit
   logic             start_frame;                  // Take the FIFO head now
   logic             line_bit;                     // Level for the current state
   logic             busy_q;                       // Tracks the delayed line

   assign bit_end     = (count == '0);

   // New frame from idle, or straight after the guard bit
   assign start_frame = ~empty & ((state == S_IDLE) | ((state == S_GUARD) & bit_end));

   //============================================================
   // Line level
   //============================================================
   always_comb begin
      if (state == S_START)
         line_bit = 1'b0;                          // Start bit, falling edge marks the frame
      else if (state <= S_D7)
         line_bit = data_q[3'(state - S_D0)];      // LSB first
      else
         line_bit = 1'b1;                          // Stop, guard and idle
   end

   // Busy covers the pop up to the end of the guard bit on the line
   assign busy = (state != S_IDLE) | busy_q;

   //============================================================
   // FSM and baud counter
   //============================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state  <= S_IDLE;
         count  <= '0;
         pop    <= 1'b0;
         txd    <= 1'b1;
         busy_q <= 1'b0;
      end else begin
         pop    <= start_frame;                    // FIFO advances on the next edge
         txd    <= line_bit;                       // Registered, one cycle behind state
         busy_q <= (state != S_IDLE);

         if (start_frame) begin
            state <= S_START;
            count <= divisor - 1'b1;               // Divisor sampled per bit
         end else if (state != S_IDLE) begin
            if (!bit_end) begin
               count <= count - 1'b1;
            end else if (state == S_GUARD) begin
               state <= S_IDLE;                    // Nothing queued
            end else begin
               state <= state_t'(state + 4'd1);    // Next bit in line order
               count <= divisor - 1'b1;
            end
         end
      end
   end

   // Byte latched together with the pop
   always_ff @(posedge clk) begin
      if (start_frame)
         data_q <= rd_data;
   end

endmodule

/* uart_tx_fifo.sv */
// Circular byte FIFO between the Wishbone register block and the serializer
`timescale 1ns/1ps

module uart_tx_fifo #(
   parameter int FIFO_DEPTH = 8                    // Power of two
) (
   input  logic        clk,
   input  logic        reset,

   fifo_push_if.buffer push,                       // Write side from the register block

   // Read side toward the serializer
   input  logic        pop,
   output logic [7:0]  rd_data,
   output logic        empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);      // Pointer wraps naturally

   logic [7:0]       mem [FIFO_DEPTH];             // Byte storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;                        // Occupancy 0..FIFO_DEPTH
   logic             do_push;
   logic             do_pop;

   //============================================================
   // Flags and handshakes
   //============================================================
   assign push.full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
   assign empty      = (count == '0);
   assign push.level = count;

   assign do_push = push.wr_en & ~push.full;       // Overflow is dropped
   assign do_pop  = pop & ~empty;                  // Underflow is ignored

   // Head is visible without a read delay
   assign rd_data = mem[rd_ptr];

   //============================================================
   // Storage
   //============================================================
   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push.wr_data;
   end

   //============================================================
   // Pointers and count
   //============================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;

         // Simultaneous push and pop leave the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* uart_wb_regs.sv */
// Wishbone classic slave with data, status and divisor registers for the UART transmitter
`timescale 1ns/1ps

module uart_wb_regs
   import uart_pkg::*;
#(
   parameter int CLK_HZ = 50_000_000,              // Core clock
   parameter int BAUD   = 115_200                  // Bit rate after reset
) (
   input  logic              clk,
   input  logic              reset,

   // Wishbone classic slave
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [ADDR_W-1:0] adr,
   input  logic [31:0]       dat_w,
   output logic              ack,
   output logic [31:0]       dat_r,

   fifo_push_if.writer       push,                 // Toward the FIFO

   input  logic              busy,                 // Serializer in a frame
   output logic [DIV_W-1:0]  divisor               // Bit period to the serializer
);

   //============================================================
   // Divisor reset value
   //============================================================
   localparam int DIV_CALC = CLK_HZ / BAUD;

   // Same floor as for bus writes
   localparam logic [DIV_W-1:0] DIV_RESET =
      (DIV_CALC < MIN_DIVISOR) ? DIV_W'(MIN_DIVISOR) : DIV_W'(DIV_CALC);

   logic             req;                          // New request, not yet answered
   logic             data_wr;                      // Request is a byte push
   logic             accept;                       // Request taken this edge
   logic             div_wr;                       // Divisor update this edge
   logic [DIV_W-1:0] div_new;                      // Written value after the floor
   logic [31:0]      status_word;
   logic [31:0]      rd_word;                      // Read mux output

   //============================================================
   // Request decode
   //============================================================
   assign req     = cyc & stb & ~ack;              // ack high means this transfer is done
   assign data_wr = req & we & (adr == REG_DATA);

   // Byte writes wait here while the FIFO is full
   assign accept  = req & ~(data_wr & push.full);
   assign div_wr  = accept & we & (adr == REG_DIVISOR);

   always_comb begin
      if (dat_w[DIV_W-1:0] < DIV_W'(MIN_DIVISOR))
         div_new = DIV_W'(MIN_DIVISOR);            // Too short for the serializer
      else
         div_new = dat_w[DIV_W-1:0];
   end

   //============================================================
   // Status word and read mux
   //============================================================
   always_comb begin
      status_word                                       = '0;
      status_word[STAT_EMPTY_BIT]                       = (push.level == '0);
      status_word[STAT_FULL_BIT]                        = push.full;
      status_word[STAT_BUSY_BIT]                        = busy;
      status_word[STAT_LEVEL_LSB +: STAT_LEVEL_W]       = STAT_LEVEL_W'(push.level);
   end

   always_comb begin
      case (adr)
         REG_STATUS:  rd_word = status_word;
         REG_DIVISOR: rd_word = 32'(divisor);
         default:     rd_word = '0;                // Data and unused address read zero
      endcase
   end

   //============================================================
   // Control registers
   //============================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ack        <= 1'b0;
         push.wr_en <= 1'b0;
         divisor    <= DIV_RESET;
      end else begin
         ack        <= accept;                     // One cycle after acceptance
         push.wr_en <= accept & we & (adr == REG_DATA);
         if (div_wr)
            divisor <= div_new;                    // Serializer picks it up next bit
      end
   end

   // Read data and byte payload
   always_ff @(posedge clk) begin
      if (accept) begin
         dat_r        <= we ? 32'd0 : rd_word;
         push.wr_data <= dat_w[7:0];
      end
   end

endmodule

/* fifo_push_if.sv */
// Interface for the FIFO write side: write strobe, write byte, full flag and level
`timescale 1ns/1ps

interface fifo_push_if #(
   parameter int DEPTH = 8                     // Must match the FIFO depth
);

   localparam int LVL_W = $clog2(DEPTH) + 1;   // Level counts 0..DEPTH

   logic             wr_en;                    // One cycle write strobe
   logic [7:0]       wr_data;                  // Byte to queue
   logic             full;                     // No room left
   logic [LVL_W-1:0] level;                    // Bytes currently held

   // Register block side
   modport writer (
      output wr_en,
      output wr_data,
      input  full,
      input  level
   );

   // FIFO side
   modport buffer (
      input  wr_en,
      input  wr_data,
      output full,
      output level
   );

endinterface

/* uart_pkg.sv */
// Register map, field widths, status bit positions and frame length for the UART transmitter
package uart_pkg;

   //============================================================
   // Wishbone register map
   //============================================================
   localparam int ADDR_W = 2;                          // Word address width on the bus

   localparam logic [ADDR_W-1:0] REG_DATA    = 2'd0;   // Write queues a byte, reads zero
   localparam logic [ADDR_W-1:0] REG_STATUS  = 2'd1;   // Read only
   localparam logic [ADDR_W-1:0] REG_DIVISOR = 2'd2;   // Bit period in clock cycles

   //============================================================
   // Divisor and frame
   //============================================================
   localparam int DIV_W       = 16;                    // Divisor register width
   localparam int MIN_DIVISOR = 4;                     // Smaller writes are raised to this

   // Start, 8 data, stop and one guard bit
   localparam int FRAME_BITS  = 11;

   //============================================================
   // Status word layout
   //============================================================
   localparam int STAT_EMPTY_BIT = 0;                  // FIFO empty
   localparam int STAT_FULL_BIT  = 1;                  // FIFO full
   localparam int STAT_BUSY_BIT  = 2;                  // Serializer sending a frame

   // FIFO level field
   localparam int STAT_LEVEL_LSB = 8;
   localparam int STAT_LEVEL_W   = 8;

endpackage
